// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/bus_pkg.sv
package bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;     // One strobe per byte lane.

    // Driven by the master.
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
        logic [STRB_W-1:0] pstrb;
    } apb_req_t;

    // Driven by the slave.
    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

endpackage

// File: design/cpu_types_pkg.sv
package cpu_types_pkg;

    // ************************************************************************
    // Encodings
    // ************************************************************************

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,                    // Bubble and ALU ops.
        MEM_LB   = 4'd1,
        MEM_LBU  = 4'd2,
        MEM_LH   = 4'd3,
        MEM_LHU  = 4'd4,
        MEM_LW   = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,                    // Reset value only.
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_DBE  = 5'd7,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_e;

    // ************************************************************************
    // Stage payloads
    // ************************************************************************

    typedef struct packed {
        logic in_delay_slot;
        logic is_eret;
        logic is_syscall;
        logic is_break;
        logic is_inst_adel;
        logic is_data_adel;
        logic is_data_ades;
        logic is_overflow;
        logic is_ri;
    } exc_flags_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_res;               // Address for loads and stores.
        logic [31:0] rt_data;               // Store data.
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        mem_op_e     mem_op;
        exc_flags_t  flags;
    } ex_mem_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        logic [31:0] w_reg_data;
    } mem_wb_t;

    function automatic logic is_load_op(mem_op_e op);
        return op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
    endfunction

    function automatic logic is_store_op(mem_op_e op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

endpackage

// File: design/exc_unit.sv
`timescale 1ns/1ns

module exc_unit #(
    parameter logic [31:0] EXC_VECTOR = 32'hBFC0_0380
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  cpu_types_pkg::ex_mem_t   req_i,
    input  logic                     bus_err_i,
    input  logic                     done_i,
    output logic                     kill_o,
    output logic                     exc_o,
    output logic                     eret_o,
    output logic [31:0]              redirect_pc_o,
    output logic [31:0]              epc_o,
    output cpu_types_pkg::exc_code_e cause_o,
    output logic                     bd_o,
    output logic                     exl_o
);

    import cpu_types_pkg::*;

    exc_flags_t f;
    exc_code_e  code;
    logic       dbe;

    assign f   = req_i.flags;
    assign dbe = done_i && bus_err_i;

    // Any flag from execute blocks the bus transfer.
    assign kill_o = f.is_inst_adel | f.is_ri | f.is_syscall | f.is_break |
                    f.is_overflow | f.is_data_adel | f.is_data_ades;

    assign exc_o  = kill_o || dbe;
    assign eret_o = f.is_eret && !kill_o;

    // ************************************************************************
    // Cause priority
    // ************************************************************************

    always_comb begin
        priority case (1'b1)
            f.is_inst_adel: code = EXC_ADEL;
            f.is_ri:        code = EXC_RI;
            f.is_syscall:   code = EXC_SYS;
            f.is_break:     code = EXC_BP;
            f.is_overflow:  code = EXC_OV;
            f.is_data_adel: code = EXC_ADEL;
            f.is_data_ades: code = EXC_ADES;
            default:        code = EXC_DBE;  // Bus error at completion.
        endcase
    end

    assign redirect_pc_o = exc_o ? EXC_VECTOR : epc_o;

    // ************************************************************************
    // CP0 state
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (rst_i) begin
            epc_o   <= '0;
            cause_o <= EXC_INT;
            bd_o    <= 1'b0;
            exl_o   <= 1'b0;
        end else if (exc_o) begin
            // Delay slot restarts at the branch.
            epc_o   <= f.in_delay_slot ? req_i.pc - 32'd4 : req_i.pc;
            cause_o <= code;
            bd_o    <= f.in_delay_slot;
            exl_o   <= 1'b1;
        end else if (eret_o) begin
            exl_o   <= 1'b0;
        end
    end

endmodule

// File: design/mem_access.sv
`timescale 1ns/1ns

module mem_access (
    input  logic                       clk,
    input  logic                       rst_i,
    input  cpu_types_pkg::ex_mem_t     req_i,
    input  logic                       kill_i,
    output bus_pkg::apb_req_t          apb_o,
    input  bus_pkg::apb_rsp_t          apb_i,
    output logic                       busy_o,
    output logic                       done_o,
    output logic                       bus_err_o,
    output logic [bus_pkg::DATA_W-1:0] load_data_o
);

    import cpu_types_pkg::*;
    import bus_pkg::*;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_SETUP,
        PH_ACCESS
    } phase_e;

    phase_e            state_q;
    phase_e            state_d;
    phase_e            phase;
    logic              start;
    logic [1:0]        byte_off;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] wdata;
    logic [7:0]        rd_byte;
    logic [15:0]       rd_half;

    assign start    = (req_i.mem_op != MEM_NONE) && !kill_i;
    assign byte_off = req_i.alu_res[1:0];

    // ************************************************************************
    // FSM
    // ************************************************************************

    // Setup is entered in the same cycle the op shows up in MEM.
    assign phase = (state_q == PH_ACCESS) ? PH_ACCESS :
                   (start ? PH_SETUP : PH_IDLE);

    always_comb begin
        case (phase)
            PH_SETUP:  state_d = PH_ACCESS;
            PH_ACCESS: state_d = apb_i.pready ? PH_IDLE : PH_ACCESS;
            default:   state_d = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= PH_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign done_o    = (phase == PH_ACCESS) && apb_i.pready;
    assign busy_o    = (phase == PH_SETUP) || ((phase == PH_ACCESS) && !apb_i.pready);
    assign bus_err_o = done_o && apb_i.pslverr;

    // ************************************************************************
    // Store lanes and strobes
    // ************************************************************************

    always_comb begin
        strb  = '0;
        wdata = '0;
        case (req_i.mem_op)
            MEM_SB: begin
                strb  = STRB_W'(1) << byte_off;
                wdata = {4{req_i.rt_data[7:0]}};
            end
            MEM_SH: begin
                strb  = byte_off[1] ? 4'b1100 : 4'b0011;
                wdata = {2{req_i.rt_data[15:0]}};
            end
            MEM_SW: begin
                strb  = '1;
                wdata = req_i.rt_data;
            end
            default: ;                      // Loads drive no strobes.
        endcase
    end

    // EX/MEM holds while busy, so these stay stable until completion.
    always_comb begin
        apb_o.psel    = (phase != PH_IDLE);
        apb_o.penable = (phase == PH_ACCESS);
        apb_o.pwrite  = is_store_op(req_i.mem_op);
        apb_o.paddr   = {req_i.alu_res[ADDR_W-1:2], 2'b00};
        apb_o.pwdata  = wdata;
        apb_o.pstrb   = strb;
    end

    // ************************************************************************
    // Load extension
    // ************************************************************************

    always_comb begin
        rd_byte = apb_i.prdata[8*byte_off +: 8];
        rd_half = byte_off[1] ? apb_i.prdata[31:16] : apb_i.prdata[15:0];
        case (req_i.mem_op)
            MEM_LB:  load_data_o = {{24{rd_byte[7]}}, rd_byte};
            MEM_LBU: load_data_o = {24'h0, rd_byte};
            MEM_LH:  load_data_o = {{16{rd_half[15]}}, rd_half};
            MEM_LHU: load_data_o = {16'h0, rd_half};
            default: load_data_o = apb_i.prdata;
        endcase
    end

endmodule

// File: design/mem_stage_top.sv
`timescale 1ns/1ns

module mem_stage_top #(
    parameter logic [bus_pkg::ADDR_W-1:0] EXC_VECTOR = 32'hBFC0_0380
) (
    input  logic                       clk,
    input  logic                       rst_i,
    input  cpu_types_pkg::ex_mem_t     ex_i,
    output logic                       stall_o,
    output logic                       flush_o,
    output logic [bus_pkg::ADDR_W-1:0] redirect_pc_o,
    output bus_pkg::apb_req_t          apb_o,
    input  bus_pkg::apb_rsp_t          apb_i,
    output cpu_types_pkg::mem_wb_t     wb_o,
    output logic [31:0]                epc_o,
    output cpu_types_pkg::exc_code_e   cause_o,
    output logic                       bd_o,
    output logic                       exl_o
);

    import cpu_types_pkg::*;

    ex_mem_t     ex_q;
    mem_wb_t     wb_d;
    logic [31:0] load_data;
    logic        kill;
    logic        busy;
    logic        done;
    logic        bus_err;
    logic        exc;
    logic        eret;
    logic        exmem_hold;
    logic        exmem_clear;
    logic        memwb_clear;

    stage_reg #(
        .payload_t(ex_mem_t)
    ) u_ex_mem (
        .clk     (clk),
        .rst_i   (rst_i),
        .clear_i (exmem_clear),
        .hold_i  (exmem_hold),
        .d_i     (ex_i),
        .q_o     (ex_q)
    );

    mem_access u_mem_access (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (ex_q),
        .kill_i      (kill),
        .apb_o       (apb_o),
        .apb_i       (apb_i),
        .busy_o      (busy),
        .done_o      (done),
        .bus_err_o   (bus_err),
        .load_data_o (load_data)
    );

    exc_unit #(
        .EXC_VECTOR(EXC_VECTOR)
    ) u_exc_unit (
        .clk           (clk),
        .rst_i         (rst_i),
        .req_i         (ex_q),
        .bus_err_i     (bus_err),
        .done_i        (done),
        .kill_o        (kill),
        .exc_o         (exc),
        .eret_o        (eret),
        .redirect_pc_o (redirect_pc_o),
        .epc_o         (epc_o),
        .cause_o       (cause_o),
        .bd_o          (bd_o),
        .exl_o         (exl_o)
    );

    pipe_ctrl u_pipe_ctrl (
        .busy_i        (busy),
        .exc_i         (exc),
        .eret_i        (eret),
        .stall_o       (stall_o),
        .flush_o       (flush_o),
        .exmem_hold_o  (exmem_hold),
        .exmem_clear_o (exmem_clear),
        .memwb_clear_o (memwb_clear)
    );

    // Load data replaces the ALU result on loads.
    always_comb begin
        wb_d.pc         = ex_q.pc;
        wb_d.w_reg_ena  = ex_q.w_reg_ena;
        wb_d.w_reg_dst  = ex_q.w_reg_dst;
        wb_d.w_reg_data = is_load_op(ex_q.mem_op) ? load_data : ex_q.alu_res;
    end

    stage_reg #(
        .payload_t(mem_wb_t)
    ) u_mem_wb (
        .clk     (clk),
        .rst_i   (rst_i),
        .clear_i (memwb_clear),
        .hold_i  (1'b0),                    // WB never stalls.
        .d_i     (wb_d),
        .q_o     (wb_o)
    );

endmodule

// File: design/pipe_ctrl.sv
`timescale 1ns/1ns

module pipe_ctrl (
    input  logic busy_i,
    input  logic exc_i,
    input  logic eret_i,
    output logic stall_o,
    output logic flush_o,
    output logic exmem_hold_o,
    output logic exmem_clear_o,
    output logic memwb_clear_o
);

    // Bus wait freezes everything up to and including EX/MEM.
    assign stall_o = busy_i;

    // Exception or eret squashes the younger instruction.
    assign flush_o = exc_i || eret_i;

    // EX/MEM behaves like the classic flush/stall register.
    assign exmem_hold_o  = busy_i;
    assign exmem_clear_o = flush_o && !busy_i;

    // Bubble into WB while MEM is busy or squashed.
    assign memwb_clear_o = busy_i || flush_o;

endmodule

// File: design/stage_reg.sv
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     clear_i,
    input  logic     hold_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // Clear wins over hold, hold wins over load.
    always_ff @(posedge clk) begin
        if (rst_i || clear_i) begin
            q_o <= '0;                      // Bubble.
        end else if (!hold_i) begin
            q_o <= d_i;
        end
    end

endmodule

// File: filelist.f
design/cpu_types_pkg.sv
design/bus_pkg.sv
design/stage_reg.sv
design/mem_access.sv
design/exc_unit.sv
design/pipe_ctrl.sv
design/mem_stage_top.sv
tb/mem_stage_sva.sv
tb/mem_stage_tb.sv

// File: tb/mem_stage_sva.sv
`timescale 1ns/1ns

module mem_stage_sva (
    input logic              clk,
    input logic              rst_i,
    input bus_pkg::apb_req_t apb_o,
    input bus_pkg::apb_rsp_t apb_i,
    input logic              stall_o,
    input logic              flush_o
);

    a_setup_access: assert property (@(posedge clk) disable iff (rst_i)
        apb_o.psel && !apb_o.penable |=> apb_o.psel && apb_o.penable)
        else $error("APB access phase did not follow setup");

    // Address is held until the completing cycle.
    a_paddr_stable: assert property (@(posedge clk) disable iff (rst_i)
        apb_o.psel && !(apb_o.penable && apb_i.pready) |=> $stable(apb_o.paddr))
        else $error("paddr changed during a transfer");

    a_stall_psel: assert property (@(posedge clk) disable iff (rst_i)
        stall_o |-> apb_o.psel)
        else $error("stall_o high without an APB transfer");

    a_no_flush_stall: assert property (@(posedge clk) disable iff (rst_i)
        !(flush_o && stall_o))
        else $error("flush_o and stall_o high together");

endmodule

bind mem_stage_top mem_stage_sva u_sva (
    .clk     (clk),
    .rst_i   (rst_i),
    .apb_o   (apb_o),
    .apb_i   (apb_i),
    .stall_o (stall_o),
    .flush_o (flush_o)
);

// File: tb/mem_stage_tb.sv
`timescale 1ns/1ns

module mem_stage_tb;

    import cpu_types_pkg::*;
    import bus_pkg::*;

    localparam logic [31:0] VECTOR     = 32'hBFC0_0380;
    localparam logic [31:0] ERR_BASE   = 32'hF000_0000;  // Slave answers pslverr from here.
    localparam logic [31:0] SEED       = 32'hd498_8cf6;
    localparam int          N_INSTR    = 400;
    localparam int          MAX_CYCLES = N_INSTR * 6 + 100;
    localparam int          K_WB       = 0;
    localparam int          K_EXC      = 1;
    localparam int          K_ERET     = 2;

    logic        clk;
    logic        rst_i;
    ex_mem_t     ex_i;
    apb_rsp_t    apb_i;
    apb_req_t    apb_o;
    mem_wb_t     wb_o;
    logic        stall_o;
    logic        flush_o;
    logic [31:0] redirect_pc_o;
    logic [31:0] epc_o;
    exc_code_e   cause_o;
    logic        bd_o;
    logic        exl_o;

    ex_mem_t     exp_q[$];                  // Accepted, not yet retired.
    logic [31:0] mdl_mem[256];
    logic [31:0] slv_mem[256];
    logic [31:0] mdl_epc;
    exc_code_e   mdl_cause;
    logic        mdl_bd;
    logic        mdl_exl;
    apb_rsp_t    rsp_next;
    int          setup_cnt;
    int          xfer_cnt;
    int          wait_left;
    int          cycles;

    mem_stage_top #(
        .EXC_VECTOR(VECTOR)
    ) UUT (
        .clk           (clk),
        .rst_i         (rst_i),
        .ex_i          (ex_i),
        .stall_o       (stall_o),
        .flush_o       (flush_o),
        .redirect_pc_o (redirect_pc_o),
        .apb_o         (apb_o),
        .apb_i         (apb_i),
        .wb_o          (wb_o),
        .epc_o         (epc_o),
        .cause_o       (cause_o),
        .bd_o          (bd_o),
        .exl_o         (exl_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        fail_run("timeout, the pipeline did not drain in time");
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic fail_run(input string what);
        $display("%s at t=%0t", what, $time);
        $display("Test failures found");
        $fatal(1, "run aborted");
    endtask

    task automatic pop_expected(output ex_mem_t ins);
        if (exp_q.size() == 0) begin
            fail_run("DUT retired an instruction that was never accepted");
        end else begin
            ins = exp_q.pop_front();
        end
    endtask

    // ************************************************************************
    // Stimulus
    // ************************************************************************

    function automatic ex_mem_t gen_instr(input int idx);
        ex_mem_t ins;
        int      pick;
        logic    half;
        logic    word;
        ins           = '0;
        pick          = $urandom_range(0, 99);
        ins.pc        = 32'h0040_0000 + 32'(idx) * 32'd4;
        ins.alu_res   = $urandom;
        ins.rt_data   = $urandom;
        ins.w_reg_dst = 5'($urandom_range(1, 31));
        if (pick < 40) begin
            ins.w_reg_ena = ($urandom_range(0, 9) != 0);    // ALU op.
        end else if (pick < 95) begin
            ins.mem_op = mem_op_e'($urandom_range(1, 8));
            half = ins.mem_op inside {MEM_LH, MEM_LHU, MEM_SH};
            word = ins.mem_op inside {MEM_LW, MEM_SW};
            ins.alu_res[31:10] = ($urandom_range(0, 19) == 0) ? 22'h3C_0000 : 22'h0;
            if ($urandom_range(0, 9) != 0) begin
                if (half) ins.alu_res[0] = 1'b0;
                if (word) ins.alu_res[1:0] = 2'b00;
            end
            ins.w_reg_ena = ins.mem_op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
            if ((half && ins.alu_res[0]) || (word && ins.alu_res[1:0] != 2'b00)) begin
                ins.flags.is_data_adel = ins.w_reg_ena;
                ins.flags.is_data_ades = !ins.w_reg_ena;
            end
        end else begin
            ins.flags.is_eret = 1'b1;
        end
        ins.flags.in_delay_slot = ($urandom_range(0, 7) == 0);
        ins.flags.is_syscall    = ($urandom_range(0, 59) == 0);
        ins.flags.is_break      = ($urandom_range(0, 59) == 0);
        ins.flags.is_inst_adel  = ($urandom_range(0, 59) == 0);
        ins.flags.is_overflow   = ($urandom_range(0, 59) == 0);
        ins.flags.is_ri         = ($urandom_range(0, 59) == 0);
        return ins;
    endfunction

    // ************************************************************************
    // Reference model
    // ************************************************************************

    function automatic exc_code_e cause_of(input exc_flags_t f);
        if (f.is_inst_adel) return EXC_ADEL;
        if (f.is_ri) return EXC_RI;
        if (f.is_syscall) return EXC_SYS;
        if (f.is_break) return EXC_BP;
        if (f.is_overflow) return EXC_OV;
        if (f.is_data_adel) return EXC_ADEL;
        if (f.is_data_ades) return EXC_ADES;
        return EXC_DBE;
    endfunction

    task automatic resolve(input ex_mem_t ins, output int kind, output logic [31:0] data);
        exc_flags_t  f;
        logic        killed;
        logic        is_mem;
        logic [1:0]  off;
        logic [7:0]  idx;
        logic [31:0] w;
        f      = ins.flags;
        killed = f.is_inst_adel | f.is_ri | f.is_syscall | f.is_break | f.is_overflow |
                 f.is_data_adel | f.is_data_ades;
        is_mem = (ins.mem_op != MEM_NONE);
        off    = ins.alu_res[1:0];
        idx    = ins.alu_res[9:2];
        w      = mdl_mem[idx];
        data   = ins.alu_res;
        kind   = K_WB;
        if (is_mem && !killed) xfer_cnt++;
        if (killed || (is_mem && ins.alu_res >= ERR_BASE)) begin
            kind      = K_EXC;
            mdl_epc   = f.in_delay_slot ? ins.pc - 32'd4 : ins.pc;
            mdl_cause = cause_of(f);
            mdl_bd    = f.in_delay_slot;
            mdl_exl   = 1'b1;
        end else if (f.is_eret) begin
            kind    = K_ERET;
            mdl_exl = 1'b0;
        end else begin
            case (ins.mem_op)
                MEM_LB:  data = {{24{w[8*off+7]}}, w[8*off +: 8]};
                MEM_LBU: data = {24'h0, w[8*off +: 8]};
                MEM_LH:  data = {{16{w[16*off[1]+15]}}, w[16*off[1] +: 16]};
                MEM_LHU: data = {16'h0, w[16*off[1] +: 16]};
                MEM_LW:  data = w;
                MEM_SB:  mdl_mem[idx][8*off +: 8] = ins.rt_data[7:0];
                MEM_SH:  mdl_mem[idx][16*off[1] +: 16] = ins.rt_data[15:0];
                MEM_SW:  mdl_mem[idx] = ins.rt_data;
                default: ;
            endcase
        end
    endtask

    task automatic check_cycle();
        ex_mem_t     ins;
        int          kind;
        logic [31:0] data;
        logic [31:0] epc_before;
        check_val("epc_o", epc_o, mdl_epc);
        check_val("cause_o", 32'(cause_o), 32'(mdl_cause));
        check_val("bd_o", 32'(bd_o), 32'(mdl_bd));
        check_val("exl_o", 32'(exl_o), 32'(mdl_exl));
        if (wb_o.pc != 32'h0) begin
            pop_expected(ins);
            resolve(ins, kind, data);
            if (kind != K_WB) begin
                fail_run("an instruction with an exception or eret reached writeback");
            end else begin
                check_val("wb_o.pc", wb_o.pc, ins.pc);
                check_val("wb_o.w_reg_ena", 32'(wb_o.w_reg_ena), 32'(ins.w_reg_ena));
                if (ins.w_reg_ena) begin
                    check_val("wb_o.w_reg_dst", 32'(wb_o.w_reg_dst), 32'(ins.w_reg_dst));
                    check_val("wb_o.w_reg_data", wb_o.w_reg_data, data);
                end
            end
        end else begin
            check_val("wb_o.w_reg_ena", 32'(wb_o.w_reg_ena), 32'h0);  // Bubble.
        end
        if (flush_o) begin
            epc_before = mdl_epc;
            pop_expected(ins);
            resolve(ins, kind, data);
            if (kind == K_WB) begin
                fail_run("flush_o raised for an instruction without exception or eret");
            end else begin
                check_val("redirect_pc_o", redirect_pc_o, (kind == K_EXC) ? VECTOR : epc_before);
            end
        end
    endtask

    // APB slave answering on the next rising edge.
    task automatic serve_apb();
        rsp_next = apb_i;
        if (apb_o.psel && !apb_o.penable) begin
            setup_cnt++;
            wait_left        = $urandom_range(0, 3);
            rsp_next.prdata  = slv_mem[apb_o.paddr[9:2]];
            rsp_next.pslverr = (apb_o.paddr >= ERR_BASE);
            rsp_next.pready  = (wait_left == 0);
        end else if (apb_o.psel && !apb_i.pready) begin
            wait_left--;
            rsp_next.pready = (wait_left == 0);
        end else begin
            if (apb_o.psel && apb_o.pwrite && !apb_i.pslverr) begin
                for (int i = 0; i < 4; i++) begin
                    if (apb_o.pstrb[i]) begin
                        slv_mem[apb_o.paddr[9:2]][8*i +: 8] = apb_o.pwdata[8*i +: 8];
                    end
                end
            end
            rsp_next = '0;
        end
    endtask

    // ************************************************************************
    // Main sequence
    // ************************************************************************

    initial begin
        ex_mem_t cur;
        int      issued;
        void'($urandom(SEED));
        for (int i = 0; i < 256; i++) begin
            slv_mem[i] = (32'(i) * 32'h9E37_79B1) ^ 32'h5A3C_96E1;
            mdl_mem[i] = slv_mem[i];
        end
        rst_i     = 1'b1;
        ex_i      = '0;
        apb_i     = '0;
        rsp_next  = '0;
        cur       = '0;
        issued    = 0;
        mdl_epc   = '0;
        mdl_cause = EXC_INT;
        mdl_bd    = 1'b0;
        mdl_exl   = 1'b0;
        setup_cnt = 0;
        xfer_cnt  = 0;
        wait_left = 0;
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;
        while (issued < N_INSTR || cur.pc != 32'h0 || exp_q.size() != 0) begin
            @(negedge clk);
            check_cycle();
            serve_apb();
            if (!stall_o) begin
                if (!flush_o && cur.pc != 32'h0) exp_q.push_back(cur);   // Dropped on flush.
                if (issued < N_INSTR) begin
                    cur = gen_instr(issued);
                    issued++;
                end else begin
                    cur = '0;
                end
            end
            @(posedge clk);
            ex_i  <= cur;
            apb_i <= rsp_next;
        end
        repeat (4) begin
            @(negedge clk);
            check_cycle();
        end
        if (setup_cnt != xfer_cnt) begin
            check_val("psel setups", setup_cnt, xfer_cnt);
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule
